// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bus_tb
FLAGS     ?= --assert
BIN       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the result"
	@echo "  clean  remove the obj_dir build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR, TOP, FLAGS"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f build.f
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== bench/bus_chk.sv ====
module bus_chk #(
    parameter int NUM_MASTERS = 2
) (
    input logic                   bus_clk,
    input logic                   rst_n,
    input logic [NUM_MASTERS-1:0] req_valid,
    input logic [NUM_MASTERS-1:0] rsp_valid
);

    // Transfer phase seen from the ports, 0 means the bus is free
    logic [1:0] phase;
    logic       sampled;

    assign sampled = (phase == 2'd0) && (|req_valid);

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= 2'd0;
        end else if (sampled || phase != 2'd0) begin
            phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
        end
    end

    a_one_rsp: assert property (@(posedge bus_clk) disable iff (!rst_n)
        $onehot0(rsp_valid))
        else $error("more than one rsp_valid bit high");

    a_pulse: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (|rsp_valid) |=> !(|rsp_valid))
        else $error("rsp_valid held longer than one cycle");

    // Response edge two cycles after the sampling edge, visible one edge later
    a_latency: assert property (@(posedge bus_clk) disable iff (!rst_n)
        sampled |=> !(|rsp_valid) ##1 !(|rsp_valid) ##1 (|rsp_valid))
        else $error("response not two cycles after the sampled request");

endmodule

bind bus_top bus_chk #(.NUM_MASTERS(NUM_MASTERS)) u_bus_chk (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid)
);

// ==== bench/bus_tb.sv ====
module bus_tb;

    localparam int          CLK_PERIOD  = 100;
    localparam int          DRIVE_DLY   = 1;
    localparam int          NUM_MASTERS = 2;
    localparam int          SLAVE_WORDS = 16;
    localparam int          RAND_XFERS  = 20;
    // Transfers per test in test order
    localparam int          NUM_XFERS   = 8 + NUM_MASTERS * RAND_XFERS + 8 + 7;
    localparam logic [31:0] LCG_SEED    = 32'h077ec5a5;

    logic                                bus_clk;
    logic                                rst_n;
    bus_pkg::bus_req_t [NUM_MASTERS-1:0] req;
    logic [NUM_MASTERS-1:0]              req_valid;
    bus_pkg::bus_rsp_t                   rsp;
    logic [NUM_MASTERS-1:0]              rsp_valid;
    logic                                btn_up;
    logic                                btn_down;
    logic [7:0]                          led8;
    logic [3:0]                          led4;

    bus_pkg::data_t    model_mem [4][SLAVE_WORDS];
    logic [7:0]        model_cnt [8];
    bus_pkg::bus_req_t pending [NUM_MASTERS][$];
    bus_pkg::bus_req_t rand_req [NUM_MASTERS][RAND_XFERS];
    logic [31:0]       lcg_state;
    string             test_name;
    int                errors;
    int                errors_at_start;
    int                num_tests;
    int                failed_tests;
    int                served;
    int                last_master;
    logic              check_alt;

    bus_top #(.NUM_MASTERS(NUM_MASTERS), .SLAVE_WORDS(SLAVE_WORDS)) uut (
        .bus_clk (bus_clk), .rst_n (rst_n), .req (req), .req_valid (req_valid),
        .rsp (rsp), .rsp_valid (rsp_valid), .btn_up (btn_up), .btn_down (btn_down),
        .led8 (led8), .led4 (led4)
    );

    always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Window number of an address or -1 when unmapped
    function automatic int window_of(bus_pkg::addr_t a);
        case (a[31:28])
            4'h0: return 0;
            4'h1: return 1;
            4'h2: return 2;
            4'hA: return 3;
            default: return -1;
        endcase
    endfunction

    function automatic bus_pkg::bus_rsp_t model_access(bus_pkg::bus_req_t r);
        bus_pkg::bus_rsp_t res;
        int s;
        int w;
        s = window_of(r.addr);
        w = int'(r.addr[31:2]) % SLAVE_WORDS;
        res.resp  = (s < 0) ? bus_pkg::RESP_DECERR : bus_pkg::RESP_OKAY;
        res.rdata = '0;
        if (s >= 0 && r.write) begin
            for (int b = 0; b < 4; b++) begin
                if (r.strb[b]) begin
                    model_mem[s][w][8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
        end else if (s >= 0) begin
            res.rdata = model_mem[s][w];
        end
        return res;
    endfunction

    function automatic bus_pkg::bus_req_t mk_req(logic wr, bus_pkg::addr_t a,
                                                 bus_pkg::data_t d, bus_pkg::strb_t st);
        return '{write: wr, addr: a, wdata: d, strb: st};
    endfunction

    // Holds the request until the response pulse and then releases it
    task automatic do_xfer(input int m, input bus_pkg::bus_req_t r);
        req[m]       = r;
        req_valid[m] = 1'b1;
        pending[m].push_back(r);
        do begin
            @(posedge bus_clk);
            #DRIVE_DLY;
        end while (!rsp_valid[m]);
        req_valid[m] = 1'b0;
    endtask

    task automatic run_master(input int m);
        for (int i = 0; i < RAND_XFERS; i++) begin
            do_xfer(m, rand_req[m][i]);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        num_tests++;
    endtask

    task automatic end_test();
        @(posedge bus_clk);
        #DRIVE_DLY;
        if (errors == errors_at_start) begin
            $display("test %s: pass", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
            failed_tests++;
        end
    endtask

    // One button press moves the index on the first edge
    task automatic press_and_check(input logic up, input int idx);
        if (up) btn_up = 1'b1;
        else btn_down = 1'b1;
        @(posedge bus_clk);
        #DRIVE_DLY;
        btn_up   = 1'b0;
        btn_down = 1'b0;
        if (led4 !== 4'(idx)) begin
            $display("Fail %s led4: expected %0d actual %0d", test_name, idx, led4);
            errors++;
        end
        if (led8 !== model_cnt[idx]) begin
            $display("Fail %s led8[%0d]: expected %0d actual %0d", test_name, idx,
                     model_cnt[idx], led8);
            errors++;
        end
        @(posedge bus_clk);
        #DRIVE_DLY;
    endtask

    always @(negedge bus_clk) begin : compare_rsp
        bus_pkg::bus_req_t r;
        bus_pkg::bus_rsp_t exp_rsp;
        int m;
        int s;
        if (rst_n && (|rsp_valid)) begin
            m = 0;
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (rsp_valid[i]) m = i;
            end
            if (pending[m].size() == 0) begin
                $display("Response to master %0d with no request outstanding", m);
                errors++;
            end else begin
                r       = pending[m].pop_front();
                exp_rsp = model_access(r);
                s       = window_of(r.addr);
                model_cnt[m] = model_cnt[m] + 8'd1;
                if (s >= 0) model_cnt[s + 2] = model_cnt[s + 2] + 8'd1;
                else model_cnt[6] = model_cnt[6] + 8'd1;
                model_cnt[7] = model_cnt[7] + 8'd1;
                if (rsp !== exp_rsp) begin
                    $display("Fail %s: expected resp %0d data %h, actual resp %0d data %h",
                             test_name, exp_rsp.resp, exp_rsp.rdata, rsp.resp, rsp.rdata);
                    errors++;
                end
                if (check_alt && served > 0 && m == last_master) begin
                    $display("Grant did not alternate, master %0d served twice", m);
                    errors++;
                end
                last_master = m;
                served++;
            end
        end
    end

    initial begin : watchdog
        // Three cycles per transfer doubled plus reset and button stepping
        repeat (NUM_XFERS * 3 * 2 + 3 + 40) @(posedge bus_clk);
        $display("The run timed out before all tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        bus_pkg::addr_t bases [4];
        logic [31:0]    v;
        logic [31:0]    d;
        logic [31:0]    w;
        bases = '{32'h0000_0000, 32'h1000_0000, 32'h2000_0000, 32'hA000_0000};
        bus_clk   = 1'b0;
        rst_n     = 1'b0;
        req       = '0;
        req_valid = '0;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
        lcg_state = LCG_SEED;
        errors    = 0;
        num_tests = 0;
        failed_tests = 0;
        served    = 0;
        last_master = 0;
        check_alt = 1'b0;
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < SLAVE_WORDS; i++) model_mem[s][i] = '0;
        end
        for (int i = 0; i < 8; i++) model_cnt[i] = '0;
        repeat (3) @(posedge bus_clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(posedge bus_clk);
        #DRIVE_DLY;

        start_test("write_read");
        for (int s = 0; s < 4; s++) begin
            d = lcg_next();
            do_xfer(0, mk_req(1'b1, bases[s] + 32'h14 + 32'(s * 8), d, 4'hF));
            do_xfer(0, mk_req(1'b0, bases[s] + 32'h14 + 32'(s * 8), '0, 4'hF));
        end
        end_test();

        start_test("two_masters");
        for (int m = 0; m < NUM_MASTERS; m++) begin
            for (int i = 0; i < RAND_XFERS; i++) begin
                v = lcg_next();
                d = lcg_next();
                w = lcg_next();
                rand_req[m][i] = mk_req(w[16], {bases[v[1:0]][31:28], v[27:2], 2'b00},
                                        d, w[11:8]);
            end
        end
        check_alt = 1'b1;
        served    = 0;
        fork
            run_master(0);
            run_master(1);
        join
        end_test();
        check_alt = 1'b0;

        start_test("decode_error");
        do_xfer(0, mk_req(1'b1, 32'h3000_0004, 32'hDEAD_BEEF, 4'hF));
        do_xfer(1, mk_req(1'b1, 32'hB000_0004, 32'hCAFE_F00D, 4'hF));
        do_xfer(0, mk_req(1'b0, 32'h3000_0004, '0, 4'hF));
        do_xfer(1, mk_req(1'b0, 32'hFFFF_FFFC, '0, 4'hF));
        // Same word offset in every mapped window stays untouched
        for (int s = 0; s < 4; s++) begin
            do_xfer(0, mk_req(1'b0, bases[s] + 32'h4, '0, 4'hF));
        end
        end_test();

        start_test("byte_strobes");
        do_xfer(0, mk_req(1'b1, 32'h1000_0020, 32'h1122_3344, 4'hF));
        do_xfer(0, mk_req(1'b1, 32'h1000_0020, 32'hAABB_CCDD, 4'b0101));
        do_xfer(0, mk_req(1'b0, 32'h1000_0020, '0, 4'hF));
        // Offset 0x60 aliases the word at 0x20
        do_xfer(1, mk_req(1'b1, 32'h1000_0060, 32'h5566_7788, 4'b1000));
        do_xfer(1, mk_req(1'b0, 32'h1000_0020, '0, 4'hF));
        do_xfer(0, mk_req(1'b1, 32'h1000_0020, 32'hFFFF_FFFF, 4'h0));
        do_xfer(0, mk_req(1'b0, 32'h1000_0020, '0, 4'hF));
        end_test();

        start_test("status_display");
        for (int i = 1; i <= 8; i++) begin
            press_and_check(1'b1, i % 8);
        end
        press_and_check(1'b0, 7);
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d errors", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
design/bus_pkg.sv
design/addr_decoder.sv
design/slave_ram.sv
design/status_display.sv
design/bus_ctrl.sv
design/bus_top.sv
bench/bus_chk.sv
bench/bus_tb.sv

// ==== design/addr_decoder.sv ====
module addr_decoder (
    input  bus_pkg::addr_t      addr,
    output bus_pkg::slave_idx_t sel,
    output logic                hit
);

    logic [bus_pkg::NUM_SLAVES-1:0] match;

    // Window compare, one bit per slave
    always_comb begin
        for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
            match[s] = (addr >= bus_pkg::SLAVE_BASE[s])
                       && (addr <= bus_pkg::SLAVE_LIMIT[s]);
        end
    end

    // Windows do not overlap, lowest match taken anyway
    always_comb begin
        sel = '0;
        for (int s = bus_pkg::NUM_SLAVES - 1; s >= 0; s--) begin
            if (match[s]) begin
                sel = bus_pkg::slave_idx_t'(s);
            end
        end
    end

    assign hit = |match;

endmodule

// ==== design/bus_ctrl.sv ====
module bus_ctrl #(
    parameter int NUM_MASTERS = 2,
    parameter int SLAVE_WORDS = 16,
    localparam int IW = (SLAVE_WORDS > 1) ? $clog2(SLAVE_WORDS) : 1,
    localparam int MW = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1
) (
    input  logic                                      bus_clk,
    input  logic                                      rst_n,
    input  bus_pkg::bus_req_t [NUM_MASTERS-1:0]       req,
    input  logic              [NUM_MASTERS-1:0]       req_valid,
    output bus_pkg::bus_rsp_t                         rsp,
    output logic              [NUM_MASTERS-1:0]       rsp_valid,
    output bus_pkg::addr_t                            dec_addr,
    input  bus_pkg::slave_idx_t                       sel,
    input  logic                                      hit,
    output logic              [bus_pkg::NUM_SLAVES-1:0] ram_en,
    output logic                                      ram_write,
    output logic              [IW-1:0]                ram_index,
    output bus_pkg::data_t                            ram_wdata,
    output bus_pkg::strb_t                            ram_strb,
    input  bus_pkg::data_t    [bus_pkg::NUM_SLAVES-1:0] ram_rdata,
    output bus_pkg::bus_done_t                        done
);

    bus_pkg::ctrl_state_t state;
    bus_pkg::bus_req_t    cur_req;
    logic [MW-1:0]        grant;
    logic [MW-1:0]        pick;

    // Round robin, search starts just after the last master served
    always_comb begin : rr_pick
        int cand;
        pick = grant;
        for (int i = NUM_MASTERS; i >= 1; i--) begin
            cand = (int'(grant) + i) % NUM_MASTERS;
            if (req_valid[cand]) begin
                pick = MW'(cand);
            end
        end
    end

    // Latched request drives the decoder and the slaves
    assign dec_addr  = cur_req.addr;
    assign ram_write = cur_req.write;
    assign ram_wdata = cur_req.wdata;
    assign ram_strb  = cur_req.strb;
    // Word index aliases within a window
    assign ram_index = IW'(cur_req.addr[31:2] % SLAVE_WORDS);

    always_comb begin
        for (int s = 0; s < bus_pkg::NUM_SLAVES; s++) begin
            ram_en[s] = (state == bus_pkg::ST_ACCESS) && hit
                        && (sel == bus_pkg::slave_idx_t'(s));
        end
    end

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= bus_pkg::ST_IDLE;
            grant     <= MW'(NUM_MASTERS - 1);
            rsp_valid <= '0;
            done      <= '0;
        end else begin
            rsp_valid  <= '0;
            done.valid <= 1'b0;
            case (state)
                bus_pkg::ST_IDLE: begin
                    if (|req_valid) begin
                        grant <= pick;
                        state <= bus_pkg::ST_ACCESS;
                    end
                end
                bus_pkg::ST_ACCESS: begin
                    state <= bus_pkg::ST_RESPOND;
                end
                bus_pkg::ST_RESPOND: begin
                    rsp_valid[grant] <= 1'b1;
                    done.valid       <= 1'b1;
                    done.master      <= grant[0];
                    done.hit         <= hit;
                    done.slave       <= sel;
                    done.resp        <= hit ? bus_pkg::RESP_OKAY : bus_pkg::RESP_DECERR;
                    state            <= bus_pkg::ST_IDLE;
                end
                default: state <= bus_pkg::ST_IDLE;
            endcase
        end
    end

    // Payload side of the transfer
    always_ff @(posedge bus_clk) begin
        if (state == bus_pkg::ST_IDLE && |req_valid) begin
            cur_req <= req[pick];
        end
        if (state == bus_pkg::ST_RESPOND) begin
            rsp.resp  <= hit ? bus_pkg::RESP_OKAY : bus_pkg::RESP_DECERR;
            // Writes and decode errors carry zero data
            rsp.rdata <= (hit && !cur_req.write) ? ram_rdata[sel] : '0;
        end
    end

endmodule

// ==== design/bus_pkg.sv ====
package bus_pkg;

    // Basic bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    localparam int NUM_SLAVES = 4;

    typedef logic [1:0] slave_idx_t;

    // Inclusive address windows, one per slave
    localparam addr_t [0:NUM_SLAVES-1] SLAVE_BASE = {
        32'h0000_0000, 32'h1000_0000, 32'h2000_0000, 32'hA000_0000
    };
    localparam addr_t [0:NUM_SLAVES-1] SLAVE_LIMIT = {
        32'h0FFF_FFFF, 32'h1FFF_FFFF, 32'h2FFF_FFFF, 32'hAFFF_FFFF
    };

    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        resp_t resp;
        data_t rdata;
    } bus_rsp_t;

    // One completed transfer, as seen by the status display
    typedef struct packed {
        logic       valid;
        logic       master;
        logic       hit;
        slave_idx_t slave;
        resp_t      resp;
    } bus_done_t;

    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_RESPOND} ctrl_state_t;

endpackage

// ==== design/bus_top.sv ====
module bus_top #(
    parameter int NUM_MASTERS = 2,
    parameter int SLAVE_WORDS = 16,
    localparam int IW = (SLAVE_WORDS > 1) ? $clog2(SLAVE_WORDS) : 1
) (
    input  logic                                     bus_clk,
    input  logic                                     rst_n,
    input  bus_pkg::bus_req_t [NUM_MASTERS-1:0]      req,
    input  logic              [NUM_MASTERS-1:0]      req_valid,
    output bus_pkg::bus_rsp_t                        rsp,
    output logic              [NUM_MASTERS-1:0]      rsp_valid,
    input  logic                                     btn_up,
    input  logic                                     btn_down,
    output logic              [7:0]                  led8,
    output logic              [3:0]                  led4
);

    bus_pkg::addr_t                              dec_addr;
    bus_pkg::slave_idx_t                         sel;
    logic                                        hit;
    logic           [bus_pkg::NUM_SLAVES-1:0]    ram_en;
    logic                                        ram_write;
    logic           [IW-1:0]                     ram_index;
    bus_pkg::data_t                              ram_wdata;
    bus_pkg::strb_t                              ram_strb;
    bus_pkg::data_t [bus_pkg::NUM_SLAVES-1:0]    ram_rdata;
    bus_pkg::bus_done_t                          done;

    bus_ctrl #(
        .NUM_MASTERS (NUM_MASTERS),
        .SLAVE_WORDS (SLAVE_WORDS)
    ) u_bus_ctrl (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .dec_addr  (dec_addr),
        .sel       (sel),
        .hit       (hit),
        .ram_en    (ram_en),
        .ram_write (ram_write),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_strb  (ram_strb),
        .ram_rdata (ram_rdata),
        .done      (done)
    );

    addr_decoder u_addr_decoder (
        .addr (dec_addr),
        .sel  (sel),
        .hit  (hit)
    );

    // One word memory per address window
    for (genvar s = 0; s < bus_pkg::NUM_SLAVES; s++) begin : g_slave
        slave_ram #(
            .SLAVE_WORDS (SLAVE_WORDS)
        ) u_slave_ram (
            .bus_clk (bus_clk),
            .rst_n   (rst_n),
            .en      (ram_en[s]),
            .write   (ram_write),
            .index   (ram_index),
            .wdata   (ram_wdata),
            .strb    (ram_strb),
            .rdata   (ram_rdata[s])
        );
    end

    status_display u_status_display (
        .bus_clk  (bus_clk),
        .rst_n    (rst_n),
        .done     (done),
        .btn_up   (btn_up),
        .btn_down (btn_down),
        .led8     (led8),
        .led4     (led4)
    );

endmodule

// ==== design/slave_ram.sv ====
module slave_ram #(
    parameter int SLAVE_WORDS = 16,
    localparam int IW = (SLAVE_WORDS > 1) ? $clog2(SLAVE_WORDS) : 1
) (
    input  logic           bus_clk,
    input  logic           rst_n,
    input  logic           en,
    input  logic           write,
    input  logic [IW-1:0]  index,
    input  bus_pkg::data_t wdata,
    input  bus_pkg::strb_t strb,
    output bus_pkg::data_t rdata
);

    localparam int LANES = $bits(bus_pkg::strb_t);

    bus_pkg::data_t mem [SLAVE_WORDS];

    // Write side, byte lanes gated by strb
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < SLAVE_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (en && write) begin
            for (int b = 0; b < LANES; b++) begin
                if (strb[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (en && !write) begin
            rdata <= mem[index];
        end
    end

endmodule

// ==== design/status_display.sv ====
module status_display (
    input  logic               bus_clk,
    input  logic               rst_n,
    input  bus_pkg::bus_done_t done,
    input  logic               btn_up,
    input  logic               btn_down,
    output logic [7:0]         led8,
    output logic [3:0]         led4
);

    logic [7:0] cnt [8];
    logic [2:0] index;
    logic       btn_up_q;
    logic       btn_down_q;
    logic       up_rise;
    logic       down_rise;

    assign up_rise   = btn_up && !btn_up_q;
    assign down_rise = btn_down && !btn_down_q;

    // Index steps on button edges and wraps modulo 8
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_up_q   <= 1'b0;
            btn_down_q <= 1'b0;
            index      <= '0;
        end else begin
            btn_up_q   <= btn_up;
            btn_down_q <= btn_down;
            if (up_rise && !down_rise) begin
                index <= index + 3'd1;
            end else if (down_rise && !up_rise) begin
                index <= index - 3'd1;
            end
        end
    end

    // Counters wrap at 8 bits
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                cnt[i] <= '0;
            end
        end else if (done.valid) begin
            cnt[{2'b00, done.master}] <= cnt[{2'b00, done.master}] + 8'd1;
            if (done.hit) begin
                cnt[{1'b0, done.slave} + 3'd2] <= cnt[{1'b0, done.slave} + 3'd2] + 8'd1;
            end
            if (done.resp == bus_pkg::RESP_DECERR) begin
                cnt[6] <= cnt[6] + 8'd1;
            end
            cnt[7] <= cnt[7] + 8'd1;
        end
    end

    assign led8 = cnt[index];
    assign led4 = {1'b0, index};

endmodule
